//--- sd_macros.svh
////////////////////
// ADC constants
////////////////////

`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// Channel count and data path widths
`define SD_NUM_CHANNELS 4
`define SD_ACC_WIDTH 24
`define SD_SAMPLE_WIDTH 16

// Modulator bits that make up one output sample
`define SD_DECIMATION 64

// AXI4-Lite register map, byte addresses
`define SD_AXI_ADDR_WIDTH 8
`define SD_ADDR_CONTROL 8'h00
`define SD_ADDR_STATUS 8'h04
`define SD_ADDR_OFFSET_BASE 8'h10

`endif

//--- sd_pkg.sv
////////////////////
// ADC types
////////////////////

`include "sd_macros.svh"

package sd_pkg;

    // Signed conversion result
    typedef logic signed [`SD_SAMPLE_WIDTH-1:0] sample_t;

    // Per-channel calibration offset
    typedef logic signed [15:0] offset_t;

    // Channel number carried next to each output sample
    typedef logic [$clog2(`SD_NUM_CHANNELS)-1:0] chan_idx_t;

    // Integrator and differentiator word, wraps freely
    typedef logic [`SD_ACC_WIDTH-1:0] acc_t;

    // Control register layout
    typedef struct packed {
        logic [19:0] reserved_hi;
        logic [3:0]  invert;
        logic [3:0]  reserved_lo;
        logic [3:0]  enable;
    } control_t;

endpackage

//--- sd_cfg_if.sv
////////////////////
// Channel settings
////////////////////

`timescale 1ns/100ps

interface sd_cfg_if;

    logic            enable;
    logic            invert;
    sd_pkg::offset_t offset;
    // Pulses for one cycle when a pending sample is overwritten
    logic            overrun;

    modport regs (
        output enable,
        output invert,
        output offset,
        input  overrun
    );

    modport chan (
        input  enable,
        input  invert,
        input  offset,
        output overrun
    );

endinterface

//--- sd_sinc_filter.sv
////////////////////
// Sinc1 decimator
////////////////////

`timescale 1ns/100ps

`include "sd_macros.svh"

module sd_sinc_filter (
    input  logic          clock,
    input  logic          reset,
    input  logic          enable,
    input  logic          sd_clock,
    input  logic          sd_data,
    output sd_pkg::acc_t  count,
    output logic          window_done
);

    localparam int COUNT_W = $clog2(`SD_DECIMATION);
    localparam logic [COUNT_W-1:0] LAST_BIT = COUNT_W'(`SD_DECIMATION - 1);

    logic               sd_clock_meta;
    logic               sd_clock_sync;
    logic               sd_clock_prev;
    logic               sd_data_meta;
    logic               sd_data_sync;
    logic               rise;
    logic [COUNT_W-1:0] bit_count;
    logic               window_end;
    sd_pkg::acc_t       integrator;
    sd_pkg::acc_t       snapshot;

    // Data goes through the same two flops as the clock so both stay aligned
    assign rise = sd_clock_sync && !sd_clock_prev;

    always_ff @(posedge clock) begin
        if (!reset) begin
            sd_clock_meta <= 1'b0;
            sd_clock_sync <= 1'b0;
            sd_clock_prev <= 1'b0;
            sd_data_meta  <= 1'b0;
            sd_data_sync  <= 1'b0;
            bit_count     <= '0;
            window_end    <= 1'b0;
            window_done   <= 1'b0;
            integrator    <= '0;
            snapshot      <= '0;
        end else begin
            sd_clock_meta <= sd_clock;
            sd_clock_sync <= sd_clock_meta;
            sd_clock_prev <= sd_clock_sync;
            sd_data_meta  <= sd_data;
            sd_data_sync  <= sd_data_meta;
            if (!enable) begin
                bit_count   <= '0;
                window_end  <= 1'b0;
                window_done <= 1'b0;
                integrator  <= '0;
                snapshot    <= '0;
            end else begin
                window_end  <= 1'b0;
                window_done <= window_end;
                if (rise) begin
                    integrator <= integrator + sd_pkg::acc_t'(sd_data_sync);
                    if (bit_count == LAST_BIT) begin
                        bit_count  <= '0;
                        window_end <= 1'b1;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
                if (window_end) begin
                    snapshot <= integrator;
                end
            end
        end
    end

    // Integrator is never cleared, the modular difference gives the window sum
    always_ff @(posedge clock) begin
        if (window_end) begin
            count <= integrator - snapshot;
        end
    end

endmodule

//--- sd_channel.sv
////////////////////
// ADC channel
////////////////////

`timescale 1ns/100ps

`include "sd_macros.svh"

module sd_channel (
    input  logic             clock,
    input  logic             reset,
    input  logic             sd_clock,
    input  logic             sd_data,
    sd_cfg_if.chan           cfg,
    output logic             sample_valid,
    input  logic             sample_ready,
    output sd_pkg::sample_t  sample_data
);

    localparam int SAT_MAX = (1 << (`SD_SAMPLE_WIDTH - 1)) - 1;
    localparam int SAT_MIN = -(1 << (`SD_SAMPLE_WIDTH - 1));
    localparam sd_pkg::sample_t SAMPLE_MAX = sd_pkg::sample_t'(SAT_MAX);
    localparam sd_pkg::sample_t SAMPLE_MIN = sd_pkg::sample_t'(SAT_MIN);

    sd_pkg::acc_t    count;
    logic            window_done;
    int              sum;
    sd_pkg::sample_t clamped;
    sd_pkg::sample_t sat_q;
    sd_pkg::sample_t signed_result;
    logic            stage1_valid;
    logic            overrun_q;

    sd_sinc_filter u_filter (
        .clock       (clock),
        .reset       (reset),
        .enable      (cfg.enable),
        .sd_clock    (sd_clock),
        .sd_data     (sd_data),
        .count       (count),
        .window_done (window_done)
    );

    // Centre on half the window, then add the offset and clamp
    always_comb begin
        sum = int'(count) - `SD_DECIMATION / 2 + int'(cfg.offset);
        if (sum > SAT_MAX) begin
            clamped = SAMPLE_MAX;
        end else if (sum < SAT_MIN) begin
            clamped = SAMPLE_MIN;
        end else begin
            clamped = sd_pkg::sample_t'(sum);
        end
    end

    // The most negative value has no positive twin, so it maps to the maximum
    always_comb begin
        if (!cfg.invert) begin
            signed_result = sat_q;
        end else if (sat_q == SAMPLE_MIN) begin
            signed_result = SAMPLE_MAX;
        end else begin
            signed_result = -sat_q;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            stage1_valid <= 1'b0;
            sample_valid <= 1'b0;
            overrun_q    <= 1'b0;
        end else begin
            stage1_valid <= window_done;
            // A new sample landing on an unaccepted one counts as an overrun
            overrun_q    <= cfg.enable && stage1_valid && sample_valid && !sample_ready;
            if (!cfg.enable) begin
                sample_valid <= 1'b0;
            end else if (stage1_valid) begin
                sample_valid <= 1'b1;
            end else if (sample_ready) begin
                sample_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (window_done) begin
            sat_q <= clamped;
        end
        if (stage1_valid) begin
            sample_data <= signed_result;
        end
    end

    assign cfg.overrun = overrun_q;

endmodule

//--- sd_sample_arbiter.sv
////////////////////
// Sample arbiter
////////////////////

`timescale 1ns/100ps

`include "sd_macros.svh"

module sd_sample_arbiter (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`SD_NUM_CHANNELS-1:0] req_valid,
    output logic [`SD_NUM_CHANNELS-1:0] req_ready,
    input  sd_pkg::sample_t            req_data [`SD_NUM_CHANNELS],
    output logic                       m_valid,
    input  logic                       m_ready,
    output sd_pkg::sample_t            m_data,
    output sd_pkg::chan_idx_t          m_channel
);

    logic              can_load;
    logic              found;
    sd_pkg::chan_idx_t grant;
    sd_pkg::chan_idx_t last_grant;

    // Output register can take a new sample when empty or being drained
    assign can_load = !m_valid || m_ready;

    // Search starts at the channel after the last one served
    always_comb begin
        int idx;
        found = 1'b0;
        grant = last_grant;
        for (int i = 1; i <= `SD_NUM_CHANNELS; i++) begin
            idx = (int'(last_grant) + i) % `SD_NUM_CHANNELS;
            if (!found && req_valid[idx]) begin
                found = 1'b1;
                grant = sd_pkg::chan_idx_t'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SD_NUM_CHANNELS; i++) begin
            req_ready[i] = can_load && found && (grant == sd_pkg::chan_idx_t'(i));
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            m_valid    <= 1'b0;
            last_grant <= '0;
        end else if (can_load) begin
            m_valid <= found;
            if (found) begin
                last_grant <= grant;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (can_load && found) begin
            m_data    <= req_data[grant];
            m_channel <= grant;
        end
    end

endmodule

//--- sd_axil_regs.sv
////////////////////
// Register block
////////////////////

`timescale 1ns/100ps

`include "sd_macros.svh"

module sd_axil_regs (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`SD_AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`SD_AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    sd_cfg_if.regs                        cfg [`SD_NUM_CHANNELS]
);

    sd_pkg::control_t            control;
    sd_pkg::offset_t             offsets [`SD_NUM_CHANNELS];
    logic [`SD_NUM_CHANNELS-1:0] status;
    logic [`SD_NUM_CHANNELS-1:0] overrun;
    logic [`SD_NUM_CHANNELS-1:0] status_clear;
    logic                        write_en;
    logic                        read_en;
    logic [31:0]                 read_word;

    function automatic logic [`SD_AXI_ADDR_WIDTH-1:0] offset_addr(input int index);
        return `SD_ADDR_OFFSET_BASE + `SD_AXI_ADDR_WIDTH'(index << 2);
    endfunction

    assign write_en = awvalid && awready && wvalid && wready;
    assign read_en  = arvalid && arready;
    assign bresp    = 2'b00;
    assign rresp    = 2'b00;
    assign status_clear = (write_en && awaddr == `SD_ADDR_STATUS && wstrb[0]) ?
                          wdata[`SD_NUM_CHANNELS-1:0] : '0;

    for (genvar g = 0; g < `SD_NUM_CHANNELS; g++) begin : g_cfg
        assign cfg[g].enable = control.enable[g];
        assign cfg[g].invert = control.invert[g];
        assign cfg[g].offset = offsets[g];
        assign overrun[g]    = cfg[g].overrun;
    end

    // Address and data are taken together, one write in flight at a time
    always_ff @(posedge clock) begin
        if (!reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= !awready && awvalid && wvalid && !bvalid;
            wready  <= !awready && awvalid && wvalid && !bvalid;
            if (write_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            arready <= !arready && arvalid && !rvalid;
            if (read_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            control <= '0;
            status  <= '0;
            for (int i = 0; i < `SD_NUM_CHANNELS; i++) begin
                offsets[i] <= '0;
            end
        end else begin
            // A new overrun wins over a clear in the same cycle
            status <= (status & ~status_clear) | overrun;
            if (write_en && awaddr == `SD_ADDR_CONTROL) begin
                if (wstrb[0]) control.enable <= wdata[3:0];
                if (wstrb[1]) control.invert <= wdata[11:8];
            end
            for (int i = 0; i < `SD_NUM_CHANNELS; i++) begin
                if (write_en && awaddr == offset_addr(i)) begin
                    if (wstrb[0]) offsets[i][7:0] <= wdata[7:0];
                    if (wstrb[1]) offsets[i][15:8] <= wdata[15:8];
                end
            end
        end
    end

    // Unmapped addresses fall through to zero
    always_comb begin
        read_word = '0;
        if (araddr == `SD_ADDR_CONTROL) begin
            read_word = control;
        end else if (araddr == `SD_ADDR_STATUS) begin
            read_word[`SD_NUM_CHANNELS-1:0] = status;
        end
        for (int i = 0; i < `SD_NUM_CHANNELS; i++) begin
            if (araddr == offset_addr(i)) begin
                read_word = {16'h0000, offsets[i]};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read_en) begin
            rdata <= read_word;
        end
    end

endmodule

//--- sd_adc_top.sv
////////////////////
// Sigma-delta ADC
////////////////////

`timescale 1ns/100ps

`include "sd_macros.svh"

module sd_adc_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          sd_clock,
    input  logic [`SD_NUM_CHANNELS-1:0]   sd_data,
    input  logic [`SD_AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`SD_AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          sample_valid,
    input  logic                          sample_ready,
    output sd_pkg::sample_t               sample_data,
    output sd_pkg::chan_idx_t             sample_channel
);

    logic [`SD_NUM_CHANNELS-1:0] chan_valid;
    logic [`SD_NUM_CHANNELS-1:0] chan_ready;
    sd_pkg::sample_t             chan_data [`SD_NUM_CHANNELS];

    sd_cfg_if cfg [`SD_NUM_CHANNELS] ();

    sd_axil_regs u_regs (
        .clock   (clock),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cfg     (cfg)
    );

    // All channels share the one modulator clock
    for (genvar g = 0; g < `SD_NUM_CHANNELS; g++) begin : g_channel
        sd_channel u_channel (
            .clock        (clock),
            .reset        (reset),
            .sd_clock     (sd_clock),
            .sd_data      (sd_data[g]),
            .cfg          (cfg[g]),
            .sample_valid (chan_valid[g]),
            .sample_ready (chan_ready[g]),
            .sample_data  (chan_data[g])
        );
    end

    sd_sample_arbiter u_arbiter (
        .clock     (clock),
        .reset     (reset),
        .req_valid (chan_valid),
        .req_ready (chan_ready),
        .req_data  (chan_data),
        .m_valid   (sample_valid),
        .m_ready   (sample_ready),
        .m_data    (sample_data),
        .m_channel (sample_channel)
    );

endmodule

//--- tb_sd_adc.sv
////////////////////
// ADC testbench
////////////////////

`timescale 1ns/100ps

`include "sd_macros.svh"

module tb_sd_adc;

    localparam int NUM_ROWS       = 6;
    localparam int WINDOW_CYCLES  = `SD_DECIMATION * 4;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 * WINDOW_CYCLES + 2000;
    localparam int STALL_CYCLES   = 1000;
    localparam int DISCARD        = 2;
    localparam int KEEP           = 3;

    logic                          clock = 1'b0;
    logic                          reset;
    logic                          sd_clock;
    logic [`SD_NUM_CHANNELS-1:0]   sd_data;
    logic [`SD_AXI_ADDR_WIDTH-1:0] awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [31:0]                   wdata;
    logic [3:0]                    wstrb;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`SD_AXI_ADDR_WIDTH-1:0] araddr;
    logic                          arvalid;
    logic                          arready;
    logic [31:0]                   rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;
    logic                          sample_valid;
    logic                          sample_ready;
    sd_pkg::sample_t               sample_data;
    sd_pkg::chan_idx_t             sample_channel;

    // Stimulus table, one entry per test row
    string      table_name    [NUM_ROWS];
    int         table_density [NUM_ROWS][`SD_NUM_CHANNELS];
    int         table_offset  [NUM_ROWS][`SD_NUM_CHANNELS];
    logic [3:0] table_enable  [NUM_ROWS];
    logic [3:0] table_invert  [NUM_ROWS];
    logic       table_stall   [NUM_ROWS];
    logic       table_random  [NUM_ROWS];
    logic [3:0] table_status  [NUM_ROWS];

    int density [`SD_NUM_CHANNELS];
    int mod_div;
    int bit_index;
    int cycles = 0;
    int errors = 0;
    int errors_before;
    int tests_passed = 0;
    int tests_failed = 0;

    sd_adc_top u_dut (
        .clock          (clock),
        .reset          (reset),
        .sd_clock       (sd_clock),
        .sd_data        (sd_data),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_data    (sample_data),
        .sample_channel (sample_channel)
    );

    always #20 clock = ~clock;

    // Modulator clock runs at a quarter of the system clock, data moves on its falling edge
    always @(negedge clock) begin
        if (mod_div == 1) begin
            mod_div = 0;
            if (sd_clock) begin
                bit_index = (bit_index + 1) % `SD_DECIMATION;
                for (int c = 0; c < `SD_NUM_CHANNELS; c++) begin
                    sd_data[c] = bit_index < density[c];
                end
            end
            sd_clock = !sd_clock;
        end else begin
            mod_div = mod_div + 1;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: samples never arrived within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_sample(input sd_pkg::sample_t actual, input sd_pkg::sample_t expected,
                                input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_channel(input sd_pkg::chan_idx_t actual,
                                 input sd_pkg::chan_idx_t expected, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s gave channel %0d, expected %0d",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_status(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [`SD_AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(negedge clock);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) @(negedge clock);
        @(negedge clock);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clock);
        check_status(32'(bresp), 32'h0, "write response");
    endtask

    task automatic axi_read(input logic [`SD_AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(negedge clock);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clock);
        @(negedge clock);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clock);
        data = rdata;
        check_status(32'(rresp), 32'h0, "read response");
    endtask

    // Centre on half the window, add the offset, clamp to 16 bits, then negate if asked
    function automatic sd_pkg::sample_t expected_sample(input int ones, input int offset,
                                                        input logic invert);
        int value;
        value = ones - `SD_DECIMATION / 2 + offset;
        if (value > 32767) value = 32767;
        if (value < -32768) value = -32768;
        if (invert) value = (value == -32768) ? 32767 : -value;
        return sd_pkg::sample_t'(value);
    endfunction

    function automatic sd_pkg::chan_idx_t next_enabled(input sd_pkg::chan_idx_t from,
                                                       input logic [3:0] mask);
        sd_pkg::chan_idx_t c;
        c = from;
        for (int i = 0; i < `SD_NUM_CHANNELS; i++) begin
            c = c + 1'b1;
            if (mask[c]) return c;
        end
        return from;
    endfunction

    function automatic logic [`SD_AXI_ADDR_WIDTH-1:0] offset_address(input int c);
        return `SD_AXI_ADDR_WIDTH'(`SD_ADDR_OFFSET_BASE + 4 * c);
    endfunction

    task automatic add_row(input int row, input string name,
                           input int d0, input int d1, input int d2, input int d3,
                           input int o0, input int o1, input int o2, input int o3,
                           input logic [3:0] enable, input logic [3:0] invert,
                           input logic stall, input logic random, input logic [3:0] status);
        table_name[row]    = name;
        table_density[row] = '{d0, d1, d2, d3};
        table_offset[row]  = '{o0, o1, o2, o3};
        table_enable[row]  = enable;
        table_invert[row]  = invert;
        table_stall[row]   = stall;
        table_random[row]  = random;
        table_status[row]  = status;
    endtask

    task automatic run_row(input int r);
        int                row_offset [`SD_NUM_CHANNELS];
        sd_pkg::sample_t   expected [`SD_NUM_CHANNELS];
        int                got [`SD_NUM_CHANNELS];
        int                row_cycle;
        int                min_got;
        int                max_got;
        logic              ready_now;
        logic              done;
        logic              have_last;
        sd_pkg::chan_idx_t ch;
        sd_pkg::chan_idx_t last_ch;
        logic [31:0]       word;
        logic [3:0]        en;

        en = table_enable[r];
        sample_ready = 1'b1;
        // Disabling all channels first lets the enabled filters restart in step
        axi_write(`SD_ADDR_CONTROL, 32'h0);
        @(posedge clock);
        for (int c = 0; c < `SD_NUM_CHANNELS; c++) begin
            density[c] = table_density[r][c];
            if (table_random[r]) begin
                row_offset[c] = int'($urandom % 4001) - 2000;
            end else begin
                row_offset[c] = table_offset[r][c];
            end
            expected[c] = expected_sample(density[c], row_offset[c], table_invert[r][c]);
            got[c] = 0;
        end
        for (int c = 0; c < `SD_NUM_CHANNELS; c++) begin
            axi_write(offset_address(c), {16'h0000, 16'(row_offset[c])});
        end
        axi_write(`SD_ADDR_CONTROL, {20'h0, table_invert[r], 4'h0, en});

        row_cycle = 0;
        have_last = 1'b0;
        last_ch   = '0;
        done      = 1'b0;
        while (!done) begin
            @(negedge clock);
            ready_now = !(table_stall[r] && row_cycle < STALL_CYCLES);
            sample_ready = ready_now;
            // Nothing moves between this edge and the next rising one
            if (sample_valid && ready_now) begin
                ch = sample_channel;
                if (!en[ch]) begin
                    $display("Time %0t: a sample arrived from disabled channel %0d", $time, ch);
                    errors++;
                end else begin
                    if (got[ch] >= DISCARD) begin
                        if (have_last) begin
                            check_channel(ch, next_enabled(last_ch, en), "round-robin order");
                        end
                        check_sample(sample_data, expected[ch],
                                     $sformatf("channel %0d sample", ch));
                        last_ch   = ch;
                        have_last = 1'b1;
                    end
                    got[ch]++;
                end
            end
            row_cycle++;
            done = 1'b1;
            for (int c = 0; c < `SD_NUM_CHANNELS; c++) begin
                if (en[c] && got[c] < DISCARD + KEEP) done = 1'b0;
            end
        end
        sample_ready = 1'b1;

        if (en == 4'hF && !table_stall[r]) begin
            min_got = got[0];
            max_got = got[0];
            for (int c = 1; c < `SD_NUM_CHANNELS; c++) begin
                if (got[c] < min_got) min_got = got[c];
                if (got[c] > max_got) max_got = got[c];
            end
            if (max_got - min_got > 1) begin
                $display("Time %0t: channel sample counts are unbalanced, %0d against %0d",
                         $time, min_got, max_got);
                errors++;
            end
        end

        axi_read(`SD_ADDR_STATUS, word);
        check_status(word, {28'h0, table_status[r]}, "overrun status");
        if (table_stall[r]) begin
            axi_write(`SD_ADDR_STATUS, 32'h0000_000F);
            axi_read(`SD_ADDR_STATUS, word);
            check_status(word, 32'h0, "overrun status after clear");
        end
        axi_read(`SD_ADDR_CONTROL, word);
        check_status(word, {20'h0, table_invert[r], 4'h0, en}, "control read-back");
        for (int c = 0; c < `SD_NUM_CHANNELS; c++) begin
            axi_read(offset_address(c), word);
            check_status(word, {16'h0000, 16'(row_offset[c])}, "offset read-back");
        end
    endtask

    initial begin
        void'($urandom(32'h4984));
        reset        = 1'b0;
        sd_clock     = 1'b0;
        sd_data      = '0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'hF;
        wvalid       = 1'b0;
        bready       = 1'b1;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b1;
        sample_ready = 1'b1;
        mod_div      = 0;
        bit_index    = 0;
        density      = '{0, 0, 0, 0};

        add_row(0, "plain conversion", 0, 16, 32, 64, 0, 0, 0, 0,
                4'hF, 4'h0, 1'b0, 1'b0, 4'h0);
        add_row(1, "offset and saturation", 10, 40, 64, 0, 1000, -1000, 32767, -32768,
                4'hF, 4'h0, 1'b0, 1'b0, 4'h0);
        add_row(2, "random offsets", 5, 20, 50, 60, 0, 0, 0, 0,
                4'hF, 4'h0, 1'b0, 1'b1, 4'h0);
        add_row(3, "sign inversion", 0, 48, 32, 64, -32768, 100, 0, -5,
                4'hF, 4'hF, 1'b0, 1'b0, 4'h0);
        add_row(4, "enable gating", 20, 30, 40, 50, 0, 0, 0, 0,
                4'b0101, 4'b0100, 1'b0, 1'b0, 4'h0);
        add_row(5, "back-pressure and overrun", 8, 24, 56, 33, 0, -7, 0, 300,
                4'b1011, 4'b0010, 1'b1, 1'b0, 4'b1011);

        repeat (3) @(negedge clock);
        reset = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            errors_before = errors;
            run_row(r);
            if (errors == errors_before) begin
                tests_passed++;
                $display("Test %0d (%s): PASS", r, table_name[r]);
            end else begin
                tests_failed++;
                $display("Test %0d (%s): FAIL", r, table_name[r]);
            end
        end

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
sd_pkg.sv
sd_cfg_if.sv
sd_sinc_filter.sv
sd_channel.sv
sd_sample_arbiter.sv
sd_axil_regs.sv
sd_adc_top.sv
tb_sd_adc.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_sd_adc -o sim_sd_adc

output=$(./obj_dir/sim_sd_adc)
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
